/* flist.f */
+incdir+logic
logic/isaPkg.sv
logic/datapathPkg.sv
logic/ctrlIf.sv
logic/regFile.sv
logic/addressRegs.sv
logic/alu.sv
logic/dataPath.sv
logic/controlUnit.sv
logic/cpuTop.sv
tests/tbClock.sv
tests/cpuTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cpuTb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/cpuTb.sv */
// ------------------------------
// Runs one program twice with the second pass under random back-pressure
// Checks sample on the falling edge and memory answers 1 ns after the rising edge
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module cpuTb;

    typedef logic [`DATA_WIDTH-1:0] word_t;

    localparam logic [31:0] seed        = 32'hf66e_0ff5;
    localparam int          resetCycles = 5;
    localparam int          loopCount   = 5;
    localparam word_t       poisonAddr  = 8'hEE;

    logic  clock;
    logic  arstN;
    logic  memReqReady;
    word_t memRdData;
    logic  memReqValid;
    logic  memWrite;
    word_t memAddr;
    word_t memWrData;

    word_t       mem [256];
    word_t       progAddr;
    logic [31:0] rngState;
    word_t       refAddr[$];
    word_t       refData[$];
    int          refTest[$];
    word_t       expAddrQ[$];
    word_t       expDataQ[$];
    int          expTestQ[$];
    logic        expValid;
    word_t       expAddr;
    word_t       expData;
    logic        xferPend;
    logic        writePend;
    word_t       addrPend;
    word_t       dataPend;
    logic        firstXferSeen;
    logic        randomMode;
    logic        runDone;
    int          errorCount;
    int          testErrBase;
    int          testsDone;
    int          writesChecked;
    int          staticCount;
    int          limitCycles = 0;
    logic        xferNow;
    logic        wrNow;

    tbClock #(.periodNs(10), .resetCycles(resetCycles)) uClock (.clock(clock), .arstN(arstN));

    cpuTop DUT (
        .clock(clock), .arstN(arstN), .memReqReady(memReqReady), .memRdData(memRdData),
        .memReqValid(memReqValid), .memWrite(memWrite), .memAddr(memAddr), .memWrData(memWrData)
    );

    assign xferNow = memReqValid && memReqReady;
    assign wrNow   = xferNow && memWrite;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic isaPkg::instr_t encImm(input isaPkg::opcode_t op,
                                              input isaPkg::regIdx_t r, input word_t imm);
        return {op, 2'b00, r, imm};
    endfunction

    function automatic isaPkg::instr_t encRegs(input isaPkg::opcode_t op, input isaPkg::regIdx_t d,
                                               input isaPkg::regIdx_t a, input isaPkg::regIdx_t b);
        return {op, 2'b00, d, 2'b00, a, 2'b00, b};
    endfunction

    task automatic drawByte(output word_t value);
        rngState = lcgNext(rngState);
        value = rngState[23:16];
    endtask

    // High byte goes first at the lower address
    task automatic emit(input isaPkg::instr_t word);
        mem[progAddr] = word[15:8];
        mem[progAddr + 8'd1] = word[7:0];
        progAddr = progAddr + 8'd2;
        staticCount++;
    endtask

    task automatic expectWrite(input word_t addr, input word_t value, input int testNo);
        refAddr.push_back(addr);
        refData.push_back(value);
        refTest.push_back(testNo);
    endtask

    task automatic emitAluStore(input isaPkg::opcode_t op, input word_t addr, input word_t value);
        emit(encRegs(op, 2'd3, 2'd1, 2'd2));
        emit(encImm(isaPkg::STM, 2'd3, addr));
        expectWrite(addr, value, 3);
    endtask

    task automatic buildProgram();
        word_t v;
        word_t a;
        word_t b;
        word_t loopAddr;
        progAddr = word_t'(`RESET_PC);
        rngState = seed;
        drawByte(v);
        emit(encImm(isaPkg::LDI, 2'd0, v));
        emit(encImm(isaPkg::STM, 2'd0, 8'hA0));
        expectWrite(8'hA0, v, 2);
        drawByte(a);
        drawByte(b);
        emit(encImm(isaPkg::LDI, 2'd1, a));
        emit(encImm(isaPkg::LDI, 2'd2, b));
        emitAluStore(isaPkg::ADD, 8'hA1, word_t'(a + b));     // Modulo 256
        emitAluStore(isaPkg::SUB, 8'hA2, word_t'(a - b));
        emitAluStore(isaPkg::AND, 8'hA3, a & b);
        emitAluStore(isaPkg::OR,  8'hA4, a | b);
        emitAluStore(isaPkg::XOR, 8'hA5, a ^ b);
        emitAluStore(isaPkg::LSL, 8'hA6, word_t'(a << 1));
        emitAluStore(isaPkg::LSR, 8'hA7, a >> 1);
        drawByte(v);
        mem[8'hC0] = v;     // Data byte for LDM
        emit(encImm(isaPkg::LDM, 2'd0, 8'hC0));
        emit(encRegs(isaPkg::MOV, 2'd1, 2'd0, 2'd0));
        emit(encImm(isaPkg::STM, 2'd1, 8'hA8));
        expectWrite(8'hA8, v, 4);
        emit(encImm(isaPkg::LDI, 2'd0, word_t'(loopCount)));
        emit(encImm(isaPkg::LDI, 2'd1, 8'h00));
        emit(encImm(isaPkg::LDI, 2'd2, 8'h01));
        loopAddr = progAddr;
        emit(encRegs(isaPkg::ADD, 2'd1, 2'd1, 2'd2));
        emit(encRegs(isaPkg::SUB, 2'd0, 2'd0, 2'd2));     // Z set on the last pass
        emit(encImm(isaPkg::BNE, 2'd0, loopAddr));
        emit(encImm(isaPkg::STM, 2'd1, 8'hA9));
        expectWrite(8'hA9, word_t'(loopCount), 5);
        emit(encImm(isaPkg::BRA, 2'd0, progAddr + 8'd4));     // Skips the poison store
        emit(encImm(isaPkg::STM, 2'd1, poisonAddr));
        emit(encImm(isaPkg::STM, 2'd0, 8'hAA));
        expectWrite(8'hAA, 8'h00, 5);
        emit(encImm(isaPkg::BRA, 2'd0, word_t'(`RESET_PC)));
    endtask

    task automatic refreshExpected();
        expValid = (expAddrQ.size() > 0);
        expAddr  = expValid ? expAddrQ[0] : '0;
        expData  = expValid ? expDataQ[0] : '0;
    endtask

    task automatic loadExpected(input logic rerun);
        for (int i = 0; i < refAddr.size(); i++) begin
            expAddrQ.push_back(refAddr[i]);
            expDataQ.push_back(refData[i]);
            expTestQ.push_back(rerun ? 6 : refTest[i]);
        end
        refreshExpected();
    endtask

    task automatic reportTest(input int testNo);
        $display("Test %0d done, %0d errors", testNo, errorCount - testErrBase);
        testErrBase = errorCount;
        testsDone++;
    endtask

    task automatic retireWrite();
        int testNo;
        writesChecked++;
        if (expAddrQ.size() == 0) return;
        testNo = expTestQ[0];
        expAddrQ.delete(0);
        expDataQ.delete(0);
        expTestQ.delete(0);
        if (expTestQ.size() == 0 || expTestQ[0] != testNo) reportTest(testNo);
        if (expTestQ.size() == 0) begin
            if (testNo == 6) begin
                runDone = 1'b1;
            end else begin
                randomMode = 1'b1;     // Second pass with a stalling memory
                loadExpected(1'b1);
            end
        end
        refreshExpected();
    endtask

    always @(negedge clock) begin
        xferPend  = xferNow;
        writePend = wrNow;
        addrPend  = memAddr;
        dataPend  = memWrData;
    end

    // Memory model acting on the transfer seen in the previous low phase
    always @(posedge clock) begin
        if (xferPend && !firstXferSeen) begin
            firstXferSeen = 1'b1;
            reportTest(1);
        end
        if (writePend) begin
            mem[addrPend] = dataPend;
            retireWrite();
        end
        #1;
        if (randomMode) begin
            rngState = lcgNext(rngState);
            memReqReady = rngState[24];
        end else begin
            memReqReady = 1'b1;
        end
        memRdData = mem[memAddr];
    end

    resetQuiet: assert property (@(negedge clock) (!arstN || $rose(arstN)) |-> !memReqValid)
        else begin
            $display("ERROR memReqValid = %h during or right after reset", memReqValid);
            errorCount++;
        end

    firstRead: assert property (@(negedge clock) disable iff (!arstN)
        xferNow && !firstXferSeen |-> !memWrite && memAddr == word_t'(`RESET_PC))
        else begin
            $display("ERROR first transfer memWrite = %h memAddr = %h, expected 0 and %h",
                     memWrite, memAddr, word_t'(`RESET_PC));
            errorCount++;
        end

    writeMatch: assert property (@(negedge clock) disable iff (!arstN)
        wrNow |-> expValid && memAddr == expAddr && memWrData == expData)
        else begin
            if (!expValid) $display("Unexpected write of %h to address %h", memWrData, memAddr);
            else $display("ERROR write memAddr = %h memWrData = %h, expected %h and %h",
                          memAddr, memWrData, expAddr, expData);
            errorCount++;
        end

    poisonUntouched: assert property (@(negedge clock) disable iff (!arstN)
        wrNow |-> memAddr != poisonAddr)
        else begin
            $display("ERROR memAddr = %h, the branch did not skip the store", memAddr);
            errorCount++;
        end

    requestHeld: assert property (@(negedge clock) disable iff (!arstN)
        memReqValid && !memReqReady |=> memReqValid && $stable(memAddr) && $stable(memWrite)
            && $stable(memWrData))
        else begin
            $display("ERROR stalled request changed: memReqValid = %h memAddr = %h",
                     memReqValid, memAddr);
            $display("ERROR stalled request changed: memWrite = %h memWrData = %h",
                     memWrite, memWrData);
            errorCount++;
        end

    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clock);
        $display("Timeout after %0d cycles, the program never finished", limitCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        memReqReady   = 1'b0;
        memRdData     = '0;
        xferPend      = 1'b0;
        writePend     = 1'b0;
        addrPend      = '0;
        dataPend      = '0;
        firstXferSeen = 1'b0;
        randomMode    = 1'b0;
        runDone       = 1'b0;
        errorCount    = 0;
        testErrBase   = 0;
        testsDone     = 0;
        writesChecked = 0;
        staticCount   = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_t'(i) ^ 8'hA5;
        end
        buildProgram();
        loadExpected(1'b0);
        // Two passes and three more instructions per extra loop turn
        limitCycles = (staticCount + (loopCount - 1) * 3) * 2 * 4 * 8 + resetCycles;
        wait (runDone);
        @(negedge clock);
        #1;
        $display("Tests done: %0d, writes checked: %0d, errors: %0d",
                 testsDone, writesChecked, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tbClock.sv */
// ------------------------------
// Free-running clock, reset released 1 ns after a rising edge
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
    parameter int periodNs    = 10,
    parameter int resetCycles = 5
) (
    output logic clock,
    output logic arstN
);

    initial begin
        clock = 1'b0;
        forever #(periodNs / 2) clock = ~clock;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clock);
        #1 arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* logic/cpuTop.sv */
// ------------------------------
// Core top with a single valid/ready memory port
// Read data is captured on the transfer edge
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module cpuTop (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic                   memReqReady,
    input  logic [`DATA_WIDTH-1:0] memRdData,
    output logic                   memReqValid,
    output logic                   memWrite,
    output logic [`DATA_WIDTH-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0] memWrData
);

    ctrlIf ctrlBus ();

    controlUnit uControlUnit (
        .clock      (clock),
        .arstN      (arstN),
        .ctrl       (ctrlBus.ctrl),
        .memReqReady(memReqReady),
        .memReqValid(memReqValid),
        .memWrite   (memWrite)
    );

    dataPath uDataPath (
        .clock    (clock),
        .arstN    (arstN),
        .ctrl     (ctrlBus.dp),
        .memRdData(memRdData),
        .memAddr  (memAddr),
        .memWrData(memWrData)
    );

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
// ------------------------------
// Multicycle FSM running one instruction at a time
// No request goes out until the first edge after reset
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
    input  logic clock,
    input  logic arstN,
    ctrlIf.ctrl  ctrl,
    input  logic memReqReady,
    output logic memReqValid,
    output logic memWrite
);

    typedef enum logic [1:0] {
        fetchHigh,
        fetchLow,
        execute,
        memAccess
    } state_t;

    state_t          state;
    state_t          nextState;
    logic            running;
    logic            xfer;
    isaPkg::opcode_t opcode;
    logic            isMemOp;

    assign opcode  = isaPkg::opcode_t'(ctrl.instr[15:12]);
    assign isMemOp = (opcode == isaPkg::LDM) || (opcode == isaPkg::STM);

    assign memReqValid = running && (state != execute);
    assign memWrite    = (state == memAccess) && (opcode == isaPkg::STM);
    assign xfer        = memReqValid && memReqReady;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state   <= fetchHigh;
            running <= 1'b0;
        end else begin
            state   <= nextState;
            running <= 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            fetchHigh: if (xfer) nextState = fetchLow;
            fetchLow:  if (xfer) nextState = execute;
            execute:   nextState = isMemOp ? memAccess : fetchHigh;
            default:   if (xfer) nextState = fetchHigh;
        endcase
    end

    always_comb begin
        ctrl.rfWrite    = 1'b0;
        ctrl.rfDest     = ctrl.instr[9:8];
        ctrl.rfSrcA     = ctrl.instr[5:4];
        ctrl.rfSrcB     = (opcode == isaPkg::STM) ? ctrl.instr[9:8] : ctrl.instr[1:0];
        ctrl.rfInSel    = datapathPkg::rfAlu;
        ctrl.aluOp      = datapathPkg::passA;
        ctrl.flagsWrite = 1'b0;
        ctrl.pcInc      = xfer && (state == fetchHigh || state == fetchLow);
        ctrl.pcLoad     = 1'b0;
        ctrl.arLoad     = 1'b0;
        ctrl.addrSel    = (state == memAccess) ? datapathPkg::addrAr : datapathPkg::addrPc;
        ctrl.irLoadHigh = xfer && (state == fetchHigh);
        ctrl.irLoadLow  = xfer && (state == fetchLow);

        if (state == execute) begin
            unique case (opcode)
                isaPkg::BRA: ctrl.pcLoad = 1'b1;
                isaPkg::LDI: begin
                    ctrl.rfWrite = 1'b1;
                    ctrl.rfInSel = datapathPkg::rfImm;
                end
                isaPkg::LDM, isaPkg::STM: ctrl.arLoad = 1'b1;     // Address for the memory step
                isaPkg::MOV: ctrl.rfWrite = 1'b1;
                isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR,
                isaPkg::XOR, isaPkg::LSL, isaPkg::LSR: begin
                    ctrl.rfWrite    = 1'b1;
                    ctrl.flagsWrite = 1'b1;
                    case (opcode)
                        isaPkg::ADD: ctrl.aluOp = datapathPkg::add;
                        isaPkg::SUB: ctrl.aluOp = datapathPkg::sub;
                        isaPkg::AND: ctrl.aluOp = datapathPkg::andOp;
                        isaPkg::OR:  ctrl.aluOp = datapathPkg::orOp;
                        isaPkg::XOR: ctrl.aluOp = datapathPkg::xorOp;
                        isaPkg::LSL: ctrl.aluOp = datapathPkg::lsl;
                        default:     ctrl.aluOp = datapathPkg::lsr;
                    endcase
                end
                isaPkg::BNE: ctrl.pcLoad = !ctrl.zero;
                default: ;     // No-operation
            endcase
        end else if (state == memAccess) begin
            if (opcode == isaPkg::LDM) begin
                ctrl.rfWrite = xfer;
                ctrl.rfInSel = datapathPkg::rfMem;
            end else begin
                ctrl.aluOp = datapathPkg::passB;     // Store register onto the write data
            end
        end
    end

    // A pending request holds its address source and direction
    reqHeld: assert property (
        @(posedge clock) disable iff (!arstN)
        memReqValid && !memReqReady |=>
            memReqValid && $stable(memWrite) && $stable(ctrl.addrSel)
    );

    stateKnown: assert property (
        @(posedge clock) disable iff (!arstN) !$isunknown(state)
    );

endmodule

`default_nettype wire

/* logic/dataPath.sv */
// ------------------------------
// IR, register file input mux, PC/AR and ALU
// Store data always comes out of the ALU
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module dataPath (
    input  logic               clock,
    input  logic               arstN,
    ctrlIf.dp                  ctrl,
    input  datapathPkg::byte_t memRdData,
    output datapathPkg::addr_t memAddr,
    output datapathPkg::byte_t memWrData
);

    isaPkg::instr_t      ir;
    datapathPkg::byte_t  imm;
    datapathPkg::byte_t  rfIn;
    datapathPkg::byte_t  readA;
    datapathPkg::byte_t  readB;
    datapathPkg::byte_t  aluResult;
    datapathPkg::flags_t flags;

    // High byte arrives first
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else begin
            if (ctrl.irLoadHigh) ir[`INSTR_WIDTH-1:`DATA_WIDTH] <= memRdData;
            if (ctrl.irLoadLow) ir[`DATA_WIDTH-1:0] <= memRdData;
        end
    end

    assign imm = ir[`DATA_WIDTH-1:0];

    always_comb begin
        unique case (ctrl.rfInSel)
            datapathPkg::rfImm: rfIn = imm;
            datapathPkg::rfMem: rfIn = memRdData;
            default:            rfIn = aluResult;
        endcase
    end

    regFile uRegFile (
        .clock(clock), .arstN(arstN),
        .writeEn(ctrl.rfWrite), .writeIdx(ctrl.rfDest),
        .readIdxA(ctrl.rfSrcA), .readIdxB(ctrl.rfSrcB),
        .writeData(rfIn), .readA(readA), .readB(readB)
    );

    addressRegs uAddressRegs (
        .clock(clock), .arstN(arstN),
        .pcInc(ctrl.pcInc), .pcLoad(ctrl.pcLoad), .arLoad(ctrl.arLoad),
        .addrSel(ctrl.addrSel), .loadValue(imm), .addr(memAddr)
    );

    alu uAlu (
        .clock(clock), .arstN(arstN),
        .opA(readA), .opB(readB), .op(ctrl.aluOp), .flagsWrite(ctrl.flagsWrite),
        .result(aluResult), .flags(flags)
    );

    assign memWrData  = aluResult;
    assign ctrl.instr = ir;
    assign ctrl.zero  = flags[3];

endmodule

`default_nettype wire

/* logic/alu.sv */
// ------------------------------
// Result is combinational, flags register on flagsWrite only
// Logic ops leave C and V as they were
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module alu (
    input  logic                clock,
    input  logic                arstN,
    input  datapathPkg::byte_t  opA,
    input  datapathPkg::byte_t  opB,
    input  datapathPkg::aluOp_t op,
    input  logic                flagsWrite,
    output datapathPkg::byte_t  result,
    output datapathPkg::flags_t flags
);

    logic [`DATA_WIDTH:0] sum;
    logic [`DATA_WIDTH:0] diff;     // Top bit is the borrow
    datapathPkg::flags_t  nextFlags;

    assign sum  = {1'b0, opA} + {1'b0, opB};
    assign diff = {1'b0, opA} - {1'b0, opB};

    always_comb begin
        nextFlags = flags;
        unique case (op)
            datapathPkg::passA: result = opA;
            datapathPkg::passB: result = opB;
            datapathPkg::add: begin
                result       = sum[`DATA_WIDTH-1:0];
                nextFlags[2] = sum[`DATA_WIDTH];
                nextFlags[0] = ~(opA[`DATA_WIDTH-1] ^ opB[`DATA_WIDTH-1])
                             & (opA[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);
            end
            datapathPkg::sub: begin
                result       = diff[`DATA_WIDTH-1:0];
                nextFlags[2] = diff[`DATA_WIDTH];
                nextFlags[0] = (opA[`DATA_WIDTH-1] ^ opB[`DATA_WIDTH-1])
                             & (opA[`DATA_WIDTH-1] ^ diff[`DATA_WIDTH-1]);
            end
            datapathPkg::andOp: result = opA & opB;
            datapathPkg::orOp:  result = opA | opB;
            datapathPkg::xorOp: result = opA ^ opB;
            datapathPkg::lsl: begin
                result       = {opA[`DATA_WIDTH-2:0], 1'b0};
                nextFlags[2] = opA[`DATA_WIDTH-1];     // Bit shifted out
            end
            datapathPkg::lsr: begin
                result       = {1'b0, opA[`DATA_WIDTH-1:1]};
                nextFlags[2] = opA[0];
            end
            default: result = opA;
        endcase
        nextFlags[3] = (result == '0);
        nextFlags[1] = result[`DATA_WIDTH-1];
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) flags <= '0;
        else if (flagsWrite) flags <= nextFlags;
    end

endmodule

`default_nettype wire

/* logic/addressRegs.sv */
// ------------------------------
// PC and AR. PC wraps at 256, AR only loads
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module addressRegs (
    input  logic                  clock,
    input  logic                  arstN,
    input  logic                  pcInc,
    input  logic                  pcLoad,
    input  logic                  arLoad,
    input  datapathPkg::addrSel_t addrSel,
    input  datapathPkg::addr_t    loadValue,
    output datapathPkg::addr_t    addr
);

    datapathPkg::addr_t pc;
    datapathPkg::addr_t ar;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= datapathPkg::addr_t'(`RESET_PC);
            ar <= '0;
        end else begin
            if (pcLoad) pc <= loadValue;     // Branch target
            else if (pcInc) pc <= pc + 1'b1;
            if (arLoad) ar <= loadValue;
        end
    end

    assign addr = (addrSel == datapathPkg::addrAr) ? ar : pc;

    pcSingleUpdate: assert property (
        @(posedge clock) disable iff (!arstN) !(pcInc && pcLoad)
    );

endmodule

`default_nettype wire

/* logic/regFile.sv */
// ------------------------------
// One write port, two combinational read ports
// A write is seen on the read ports after the edge
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module regFile (
    input  logic               clock,
    input  logic               arstN,
    input  logic               writeEn,
    input  isaPkg::regIdx_t    writeIdx,
    input  isaPkg::regIdx_t    readIdxA,
    input  isaPkg::regIdx_t    readIdxB,
    input  datapathPkg::byte_t writeData,
    output datapathPkg::byte_t readA,
    output datapathPkg::byte_t readB
);

    datapathPkg::byte_t regs [`REG_COUNT];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

    // The decoder must name a real register on every write
    writeIdxKnown: assert property (
        @(posedge clock) disable iff (!arstN)
        writeEn |-> !$isunknown(writeIdx)
    );

endmodule

`default_nettype wire

/* logic/ctrlIf.sv */
// ------------------------------
// Control words to the datapath, status back to the FSM
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf;

    logic                  rfWrite;
    isaPkg::regIdx_t       rfDest;
    isaPkg::regIdx_t       rfSrcA;
    isaPkg::regIdx_t       rfSrcB;
    datapathPkg::rfInSel_t rfInSel;
    datapathPkg::aluOp_t   aluOp;
    logic                  flagsWrite;
    logic                  pcInc;
    logic                  pcLoad;
    logic                  arLoad;
    datapathPkg::addrSel_t addrSel;
    logic                  irLoadHigh;
    logic                  irLoadLow;
    isaPkg::instr_t        instr;
    logic                  zero;     // Stored Z flag

    modport ctrl (output rfWrite, rfDest, rfSrcA, rfSrcB, rfInSel, aluOp, flagsWrite,
                  output pcInc, pcLoad, arLoad, addrSel, irLoadHigh, irLoadLow,
                  input  instr, zero);

    modport dp (input  rfWrite, rfDest, rfSrcA, rfSrcB, rfInSel, aluOp, flagsWrite,
                input  pcInc, pcLoad, arLoad, addrSel, irLoadHigh, irLoadLow,
                output instr, zero);

endinterface

`default_nettype wire

/* logic/datapathPkg.sv */
// ------------------------------
// Datapath word types and select codes
// Flags are Z, C, N, V from bit 3 down
// ------------------------------
`default_nettype none

`include "core_cfg.svh"

package datapathPkg;

    typedef logic [`DATA_WIDTH-1:0] byte_t;
    typedef logic [`DATA_WIDTH-1:0] addr_t;
    typedef logic [3:0]             flags_t;

    typedef enum logic [3:0] {
        passA,
        passB,
        add,
        sub,
        andOp,
        orOp,
        xorOp,
        lsl,     // Shifts work on operand A only
        lsr
    } aluOp_t;

    // Register file write source
    typedef enum logic [1:0] {
        rfImm,
        rfMem,
        rfAlu
    } rfInSel_t;

    // Memory address source
    typedef enum logic {
        addrPc,
        addrAr
    } addrSel_t;

endpackage

`default_nettype wire

/* logic/isaPkg.sv */
// ------------------------------
// Instruction encoding. Opcode in bits 15..12, immediate in 7..0
// Opcodes 13 to 15 run as no-operations
// ------------------------------
`default_nettype none

`include "core_cfg.svh"

package isaPkg;

    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // Dest or store source at 9..8, src1 at 5..4, src2 at 1..0
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

    typedef enum logic [3:0] {
        BRA = 4'd0,
        LDI = 4'd1,
        LDM = 4'd2,
        STM = 4'd3,
        MOV = 4'd4,
        ADD = 4'd5,
        SUB = 4'd6,
        AND = 4'd7,
        OR  = 4'd8,
        XOR = 4'd9,
        LSL = 4'd10,
        LSR = 4'd11,
        BNE = 4'd12
    } opcode_t;

endpackage

`default_nettype wire

/* logic/core_cfg.svh */
// ------------------------------
// Core sizes. The data byte and the address byte share one width,
// so DATA_WIDTH also sets the 256-byte address space
// ------------------------------
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address byte
`define DATA_WIDTH 8

// Two fetched bytes make one instruction
`define INSTR_WIDTH 16

`define REG_COUNT 4     // General registers R0..R3

`define RESET_PC 0      // First fetch address

`endif
